//--- design/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

`define RV_NUM_REGS 32

// first fetch after reset
`define RV_RESET_PC 32'h8000_0000

`define RV_INSN_BYTES 4

`endif

//--- design/rv_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    opc_op     = 7'b011_0011,
    opc_op_imm = 7'b001_0011,
    opc_load   = 7'b000_0011,
    opc_store  = 7'b010_0011,
    opc_branch = 7'b110_0011,
    opc_jal    = 7'b110_1111,
    opc_jalr   = 7'b110_0111,
    opc_lui    = 7'b011_0111,
    opc_auipc  = 7'b001_0111,
    opc_system = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_or,
    alu_and,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b // lui
  } alu_op_e;

  // register write source
  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_link
  } wb_sel_e;

endpackage

`default_nettype wire

//--- design/decode_if.sv
`timescale 1ns/10ps
`default_nettype none

interface decode_if;
  import rv_pkg::*;

  opcode_e   opcode;
  alu_op_e   alu_op;
  logic [2:0] funct3;    // branch condition and load/store size
  word_t     operand_a;  // rs1 or pc
  word_t     operand_b;  // rs2 or imm
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     imm;
  reg_addr_t rd;
  logic      reg_write;
  wb_sel_e   wb_sel;
  logic      is_ebreak;

  modport decode (output opcode, alu_op, funct3, operand_a, operand_b, rs1_data,
                  rs2_data, imm, rd, reg_write, wb_sel, is_ebreak);

  modport execute (input opcode, alu_op, funct3, operand_a, operand_b, rs1_data,
                   rs2_data, imm);

  modport writeback (input opcode, funct3, rs2_data, reg_write, wb_sel);

endinterface

`default_nettype wire

//--- design/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_config.svh"

module fetch_stage (
  input  logic          clk,
  input  logic          rst,
  input  logic          redirect,
  input  rv_pkg::word_t next_pc,
  input  logic          ebreak_seen,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4,
  output logic          halt
);
  import rv_pkg::*;

  word_t pc_d;

  assign pc_plus4 = pc + word_t'(`RV_INSN_BYTES); // static next pc

  always_comb begin
    if (halt || ebreak_seen) begin
      pc_d = pc; // park on the ebreak
    end else if (redirect) begin
      pc_d = next_pc;
    end else begin
      pc_d = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= `RV_RESET_PC;
      halt <= 1'b0;
    end else begin
      pc <= pc_d;
      if (ebreak_seen) begin
        halt <= 1'b1; // sticky until reset
      end
    end
  end

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  rv_pkg::word_t     insn,
  input  rv_pkg::word_t     pc,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  decode_if.decode          dec
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j, imm_shamt;
  word_t      imm;
  alu_op_e    arith_op;
  alu_op_e    alu_op;
  wb_sel_e    wb_sel;
  logic       sel_pc_a;   // operand a from pc
  logic       sel_imm_b;  // operand b from imm
  logic       reg_write;
  logic       is_ebreak;

  assign opcode   = opcode_e'(insn[6:0]);
  assign funct3   = insn[14:12];
  assign funct7   = insn[31:25];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];

  // sign extended immediates
  assign imm_i     = word_t'($signed(insn[31:20]));
  assign imm_s     = word_t'($signed({insn[31:25], insn[11:7]}));
  assign imm_b     = word_t'($signed({insn[31], insn[7], insn[30:25], insn[11:8], 1'b0}));
  assign imm_u     = {insn[31:12], 12'h000};
  assign imm_j     = word_t'($signed({insn[31], insn[19:12], insn[20], insn[30:21], 1'b0}));
  assign imm_shamt = word_t'(insn[24:20]); // slli/srli/srai

  // funct3 picks the op, funct7[5] splits add/sub and srl/sra
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = funct7[5] ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  always_comb begin
    sel_pc_a  = 1'b0;
    sel_imm_b = 1'b1;
    imm       = imm_i;
    alu_op    = alu_add;
    wb_sel    = wb_alu;
    reg_write = 1'b0;
    is_ebreak = 1'b0;
    case (opcode)
      opc_op: begin
        sel_imm_b = 1'b0;
        alu_op    = arith_op;
        reg_write = 1'b1;
      end
      opc_op_imm: begin
        alu_op    = arith_op;
        reg_write = 1'b1;
        if (funct3[1:0] == 2'b01) begin
          imm = imm_shamt;
        end
      end
      opc_load: begin
        wb_sel    = wb_load;
        reg_write = 1'b1;
      end
      opc_store:  imm = imm_s; // address = rs1 + imm
      opc_branch: begin
        sel_imm_b = 1'b0;
        imm       = imm_b;
      end
      opc_jal: begin
        imm       = imm_j;
        wb_sel    = wb_link;
        reg_write = 1'b1;
      end
      opc_jalr: begin
        wb_sel    = wb_link;
        reg_write = 1'b1;
      end
      opc_lui: begin
        imm       = imm_u;
        alu_op    = alu_pass_b;
        reg_write = 1'b1;
      end
      opc_auipc: begin
        sel_pc_a  = 1'b1;
        imm       = imm_u;
        reg_write = 1'b1;
      end
      opc_system: is_ebreak = (insn == 32'h0010_0073);
      default: ; // unknown opcode, no side effects
    endcase
  end

  assign dec.opcode    = opcode;
  assign dec.alu_op    = alu_op;
  assign dec.funct3    = funct3;
  assign dec.operand_a = sel_pc_a ? pc : rs1_data;
  assign dec.operand_b = sel_imm_b ? imm : rs2_data;
  assign dec.rs1_data  = rs1_data;
  assign dec.rs2_data  = rs2_data;
  assign dec.imm       = imm;
  assign dec.rd        = insn[11:7];
  assign dec.reg_write = reg_write;
  assign dec.wb_sel    = wb_sel;
  assign dec.is_ebreak = is_ebreak;

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_config.svh"

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::word_t     wdata
);

  rv_pkg::word_t regs [`RV_NUM_REGS];

  // x0 reads as zero whatever the array holds
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  decode_if.execute     dec,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t pc_plus4,
  output rv_pkg::word_t alu_result,
  output rv_pkg::word_t next_pc,
  output logic          redirect
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       op_lt, op_ltu;   // operand compare, for slt/sltu
  logic       br_eq, br_lt, br_ltu;
  logic       taken;
  word_t      target_base;
  word_t      target_sum;
  word_t      target;

  assign shamt  = dec.operand_b[4:0];
  assign op_lt  = $signed(dec.operand_a) < $signed(dec.operand_b);
  assign op_ltu = dec.operand_a < dec.operand_b;

  always_comb begin
    case (dec.alu_op)
      alu_add:    alu_result = dec.operand_a + dec.operand_b;
      alu_sub:    alu_result = dec.operand_a - dec.operand_b;
      alu_xor:    alu_result = dec.operand_a ^ dec.operand_b;
      alu_or:     alu_result = dec.operand_a | dec.operand_b;
      alu_and:    alu_result = dec.operand_a & dec.operand_b;
      alu_slt:    alu_result = word_t'(op_lt);
      alu_sltu:   alu_result = word_t'(op_ltu);
      alu_sll:    alu_result = dec.operand_a << shamt;
      alu_srl:    alu_result = dec.operand_a >> shamt;
      alu_sra:    alu_result = word_t'($signed(dec.operand_a) >>> shamt);
      alu_pass_b: alu_result = dec.operand_b;
      default:    alu_result = '0;
    endcase
  end

  // branch compare always on the raw register values
  assign br_eq  = dec.rs1_data == dec.rs2_data;
  assign br_lt  = $signed(dec.rs1_data) < $signed(dec.rs2_data);
  assign br_ltu = dec.rs1_data < dec.rs2_data;

  always_comb begin
    case (dec.funct3)
      3'b000:  taken = br_eq;    // beq
      3'b001:  taken = !br_eq;   // bne
      3'b100:  taken = br_lt;    // blt
      3'b101:  taken = !br_lt;   // bge
      3'b110:  taken = br_ltu;   // bltu
      3'b111:  taken = !br_ltu;  // bgeu
      default: taken = 1'b0;
    endcase
  end

  assign target_base = (dec.opcode == opc_jalr) ? dec.rs1_data : pc;
  assign target_sum  = target_base + dec.imm;
  // jalr drops bit 0 of the sum
  assign target = (dec.opcode == opc_jalr) ? {target_sum[31:1], 1'b0} : target_sum;

  assign redirect = (dec.opcode == opc_jal) || (dec.opcode == opc_jalr) ||
                    (dec.opcode == opc_branch && taken);
  assign next_pc  = redirect ? target : pc_plus4;

endmodule

`default_nettype wire

//--- design/writeback_stage.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_stage (
  decode_if.writeback   dec,
  input  rv_pkg::word_t alu_result,
  input  rv_pkg::word_t pc_plus4,
  input  logic          halt,
  input  rv_pkg::word_t dmem_rdata,
  output rv_pkg::word_t dmem_wdata,
  output logic [3:0]    dmem_wmask,
  output logic          dmem_we,
  output logic          rf_we,
  output rv_pkg::word_t rf_wdata
);
  import rv_pkg::*;

  logic [1:0] byte_off;
  logic [7:0] load_byte;
  word_t      load_data;
  logic       is_store;
  logic       is_byte;   // sb / lb / lbu size

  assign byte_off  = alu_result[1:0];
  assign load_byte = dmem_rdata[8*byte_off +: 8];
  assign is_store  = dec.opcode == opc_store;
  assign is_byte   = dec.funct3[1:0] == 2'b00;

  always_comb begin
    case (dec.funct3)
      3'b000:  load_data = word_t'($signed(load_byte)); // lb
      3'b100:  load_data = word_t'(load_byte);          // lbu
      default: load_data = dmem_rdata;                  // lw
    endcase
  end

  // byte stores go out on every lane, mask picks the one
  assign dmem_wdata = is_byte ? {4{dec.rs2_data[7:0]}} : dec.rs2_data;

  always_comb begin
    if (!is_store) begin
      dmem_wmask = 4'b0000;
    end else if (is_byte) begin
      dmem_wmask = 4'b0001 << byte_off;
    end else begin
      dmem_wmask = 4'b1111;
    end
  end

  always_comb begin
    case (dec.wb_sel)
      wb_load: rf_wdata = load_data;
      wb_link: rf_wdata = pc_plus4;  // jal/jalr return address
      default: rf_wdata = alu_result;
    endcase
  end

  assign dmem_we = is_store && !halt;
  assign rf_we   = dec.reg_write && !halt;

endmodule

`default_nettype wire

//--- design/riscv_core.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_core (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_rdata,
  output rv_pkg::word_t dmem_addr,
  input  rv_pkg::word_t dmem_rdata,
  output rv_pkg::word_t dmem_wdata,
  output logic [3:0]    dmem_wmask,
  output logic          dmem_we,
  output logic          halt
);
  import rv_pkg::*;

  word_t     pc;
  word_t     pc_plus4;
  word_t     next_pc;
  logic      redirect;
  word_t     alu_result;
  reg_addr_t rs1_addr, rs2_addr;
  word_t     rs1_data, rs2_data;
  logic      rf_we;
  word_t     rf_wdata;

  decode_if dec ();

  fetch_stage i_fetch (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .next_pc     (next_pc),
    .ebreak_seen (dec.is_ebreak),
    .pc          (pc),
    .pc_plus4    (pc_plus4),
    .halt        (halt)
  );

  decode_stage i_decode (
    .insn     (imem_rdata),
    .pc       (pc),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec      (dec.decode)
  );

  reg_file i_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .waddr    (dec.rd),
    .wdata    (rf_wdata)
  );

  execute_stage i_execute (
    .dec        (dec.execute),
    .pc         (pc),
    .pc_plus4   (pc_plus4),
    .alu_result (alu_result),
    .next_pc    (next_pc),
    .redirect   (redirect)
  );

  writeback_stage i_writeback (
    .dec        (dec.writeback),
    .alu_result (alu_result),
    .pc_plus4   (pc_plus4),
    .halt       (halt),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_we    (dmem_we),
    .rf_we      (rf_we),
    .rf_wdata   (rf_wdata)
  );

  assign imem_addr = pc;
  assign dmem_addr = alu_result; // load/store address from the adder

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int period = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk; // even duty cycle
  end

endmodule

`default_nettype wire

//--- bench/core_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module core_assertions (
  input logic        clk,
  input logic        rst,
  input logic [31:0] imem_addr,
  input logic        dmem_we,
  input logic [3:0]  dmem_wmask,
  input logic        halt
);

  pc_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else $error("imem_addr %h is not word aligned", imem_addr);

  // a store always carries at least one byte lane
  store_has_mask: assert property (@(posedge clk) disable iff (rst) dmem_we |-> dmem_wmask != 4'b0000)
    else $error("store issued with an empty byte mask");

  halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else $error("halt dropped without a reset");

  no_store_halted: assert property (@(posedge clk) disable iff (rst) halt |-> !dmem_we)
    else $error("store issued while halted");

endmodule

`default_nettype wire

//--- bench/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_config.svh"

module tb_top;

  localparam logic [31:0] reset_pc    = `RV_RESET_PC;
  localparam logic [31:0] dmem_base   = 32'h0000_1000;
  localparam logic [31:0] ebreak_insn = 32'h0010_0073;
  localparam int          imem_words  = 512;
  localparam int          dmem_words  = 1024;
  localparam int          hold_cycles = 10;

  localparam logic [6:0] op_r     = 7'b011_0011;
  localparam logic [6:0] op_i     = 7'b001_0011;
  localparam logic [6:0] op_ld    = 7'b000_0011;
  localparam logic [6:0] op_st    = 7'b010_0011;
  localparam logic [6:0] op_br    = 7'b110_0011;
  localparam logic [6:0] op_jal   = 7'b110_1111;
  localparam logic [6:0] op_jalr  = 7'b110_0111;
  localparam logic [6:0] op_lui   = 7'b011_0111;
  localparam logic [6:0] op_auipc = 7'b001_0111;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [2:0]  sec;
  } store_t;

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr, imem_rdata;
  logic [31:0] dmem_addr, dmem_rdata, dmem_wdata;
  logic [3:0]  dmem_wmask;
  logic        dmem_we;
  logic        halt;

  logic [31:0] imem [imem_words];
  logic [31:0] dmem [dmem_words];
  logic [2:0]  sec_of [imem_words]; // test section of each instruction
  store_t      exp_q [$];
  logic [2:0]  build_sec;
  logic [2:0]  cur_sec = 3'd1;
  logic [31:0] hold_pc;
  int prog_len, slot, exp_idx;
  int cycles, cycle_limit;
  int check_cnt, fail_cnt;
  int sec_fail [7];

  tb_clock #(.period(8)) i_clock (.clk(clk));

  riscv_core i_riscv_core (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_we    (dmem_we),
    .halt       (halt)
  );

  bind riscv_core core_assertions i_core_assertions (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .dmem_we    (dmem_we),
    .dmem_wmask (dmem_wmask),
    .halt       (halt)
  );

  // combinational memories, ebreak outside the program window
  assign imem_rdata = (imem_addr[31:11] == reset_pc[31:11]) ? imem[imem_addr[10:2]] : ebreak_insn;
  assign dmem_rdata = (dmem_addr[31:12] == 20'h1) ? dmem[dmem_addr[11:2]] : fill_word(dmem_addr);

  always @(posedge clk) begin
    if (!rst && dmem_we && dmem_addr[31:12] == 20'h1) begin
      for (int k = 0; k < 4; k++) begin
        if (dmem_wmask[k]) dmem[dmem_addr[11:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
      end
    end
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ (addr * 32'h9E37_79B1) ^ 32'h3C5A_96E1;
  endfunction

  // instruction encoders
  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_r};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_st};
  endfunction

  function automatic logic [31:0] btype(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_br};
  endfunction

  function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jtype(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  task automatic put(input logic [31:0] insn);
    imem[prog_len] = insn;
    sec_of[prog_len] = build_sec;
    prog_len++;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800; // addi sign-extends its low part
    put(utype(hi[31:12], rd, op_lui));
    put(itype(v[11:0], rd, 3'b000, rd, op_i));
  endtask

  task automatic save_result(input logic [4:0] rs);
    put(stype(12'(slot * 4), rs, 5'd1, 3'b010));
    slot++;
  endtask

  task automatic alu_section();
    logic [31:0] a, b;
    logic [11:0] k;
    for (int p = 0; p < 2; p++) begin
      a = $urandom;
      b = $urandom;
      k = 12'($urandom);
      load_const(5'd2, a);
      load_const(5'd3, b);
      for (int f = 0; f < 8; f++) begin
        put(rtype(7'h00, 5'd3, 5'd2, 3'(f), 5'd4));
        save_result(5'd4);
      end
      put(rtype(7'h20, 5'd3, 5'd2, 3'b000, 5'd4)); // sub
      save_result(5'd4);
      put(rtype(7'h20, 5'd3, 5'd2, 3'b101, 5'd4)); // sra
      save_result(5'd4);
      for (int f = 0; f < 8; f++) begin
        if (f != 1 && f != 5) begin
          put(itype(k, 5'd2, 3'(f), 5'd4, op_i));
          save_result(5'd4);
        end
      end
      put(itype({7'h00, k[4:0]}, 5'd2, 3'b001, 5'd4, op_i));
      save_result(5'd4);
      put(itype({7'h00, k[4:0]}, 5'd2, 3'b101, 5'd4, op_i));
      save_result(5'd4);
      put(itype({7'h20, k[4:0]}, 5'd2, 3'b101, 5'd4, op_i));
      save_result(5'd4);
    end
  endtask

  task automatic upper_section();
    put(utype(20'($urandom), 5'd4, op_lui));
    save_result(5'd4);
    put(utype(20'($urandom), 5'd4, op_auipc));
    save_result(5'd4);
  endtask

  // equal, negative vs positive, positive vs negative
  task automatic branch_section();
    logic [31:0] v, neg, va, vb;
    logic [2:0]  cond;
    v = ($urandom & 32'h3FFF_FFFF) | 32'h1;
    neg = 32'h0 - v;
    for (int p = 0; p < 3; p++) begin
      va = (p == 1) ? neg : v;
      vb = (p == 2) ? neg : v;
      load_const(5'd2, va);
      load_const(5'd3, vb);
      for (int c = 0; c < 6; c++) begin
        cond = (c < 2) ? 3'(c) : 3'(c + 2);
        put(btype(13'd12, 5'd3, 5'd2, cond));
        put(itype(12'(256 + p * 16 + c * 2), 5'd0, 3'b000, 5'd5, op_i));
        put(jtype(21'd8, 5'd0));
        put(itype(12'(257 + p * 16 + c * 2), 5'd0, 3'b000, 5'd5, op_i));
        save_result(5'd5);
      end
    end
  endtask

  task automatic jump_section();
    put(jtype(21'd8, 5'd6));
    save_result(5'd0); // skipped by the jal
    save_result(5'd6);
    put(utype(20'h0, 5'd8, op_auipc));
    put(itype(12'd13, 5'd8, 3'b000, 5'd9, op_jalr)); // odd target
    save_result(5'd8); // skipped by the jalr
    save_result(5'd9);
  endtask

  task automatic memory_section();
    load_const(5'd11, 32'h8F7A_E512); // byte signs alternate
    put(stype(12'h600, 5'd11, 5'd1, 3'b010));
    for (int k = 0; k < 4; k++) begin
      put(itype(12'(1536 + k), 5'd1, 3'b000, 5'd4, op_ld));
      save_result(5'd4);
      put(itype(12'(1536 + k), 5'd1, 3'b100, 5'd4, op_ld));
      save_result(5'd4);
    end
    put(itype(12'h600, 5'd1, 3'b010, 5'd4, op_ld));
    save_result(5'd4);
    load_const(5'd12, $urandom);
    for (int k = 0; k < 4; k++) begin
      put(stype(12'(1540 + k), 5'd12, 5'd1, 3'b000));
      put(itype(12'd8, 5'd12, 3'b101, 5'd12, op_i));
    end
    put(itype(12'h604, 5'd1, 3'b010, 5'd4, op_ld));
    save_result(5'd4);
    put(itype(12'h700, 5'd1, 3'b010, 5'd4, op_ld)); // untouched fill word
    save_result(5'd4);
  endtask

  task automatic halt_section();
    put(ebreak_insn);
    save_result(5'd4);
    save_result(5'd4);
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] y);
    case (f3)
      3'b000:  return alt ? a - y : a + y;
      3'b001:  return a << y[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(y)};
      3'b011:  return {31'b0, a < y};
      3'b100:  return a ^ y;
      3'b101:  return alt ? 32'($signed(a) >>> y[4:0]) : a >> y[4:0];
      3'b110:  return a | y;
      default: return a & y;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // ISA model on private state, fills exp_q with the store sequence
  function automatic int run_model();
    logic [31:0] r [32];
    logic [31:0] m [dmem_words];
    logic [31:0] pc, insn, a, b, y, res, addr, npc;
    logic [31:0] imm_i, imm_s, imm_b, imm_j, imm_u;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [7:0]  bt;
    logic        wr;
    store_t      st;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < dmem_words; i++) m[i] = fill_word(dmem_base + 32'(i * 4));
    exp_q.delete();
    pc = reset_pc;
    for (int steps = 0; steps < 4 * imem_words; steps++) begin
      insn = imem[pc[10:2]];
      if (insn == ebreak_insn) break;
      op    = insn[6:0];
      f3    = insn[14:12];
      a     = r[insn[19:15]];
      b     = r[insn[24:20]];
      imm_i = {{20{insn[31]}}, insn[31:20]};
      imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      imm_u = {insn[31:12], 12'h000};
      res   = '0;
      wr    = 1'b1;
      npc   = pc + 32'd4;
      case (op)
        op_r, op_i: begin
          y   = (op == op_r) ? b : imm_i;
          res = alu_ref(f3, insn[30] && (op == op_r || f3 == 3'b101), a, y);
        end
        op_lui:   res = imm_u;
        op_auipc: res = pc + imm_u;
        op_jal: begin
          res = pc + 32'd4;
          npc = pc + imm_j;
        end
        op_jalr: begin
          res = pc + 32'd4;
          npc = (a + imm_i) & ~32'h1;
        end
        op_ld: begin
          addr = a + imm_i;
          y    = m[addr[11:2]];
          bt   = y[{addr[1:0], 3'b000} +: 8];
          if (f3 == 3'b000) res = {{24{bt[7]}}, bt};
          else if (f3 == 3'b100) res = {24'h0, bt};
          else res = y;
        end
        op_br: begin
          wr = 1'b0;
          if (branch_taken(f3, a, b)) npc = pc + imm_b;
        end
        op_st: begin
          wr      = 1'b0;
          addr    = a + imm_s;
          st.addr = addr;
          st.sec  = sec_of[pc[10:2]];
          if (f3 == 3'b000) begin
            st.data = {4{b[7:0]}};
            st.mask = 4'b0001 << addr[1:0];
            m[addr[11:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
          end else begin
            st.data = b;
            st.mask = 4'b1111;
            m[addr[11:2]] = b;
          end
          exp_q.push_back(st);
        end
        default: wr = 1'b0;
      endcase
      if (wr && insn[11:7] != 5'd0) r[insn[11:7]] = res;
      pc = npc;
    end
    hold_pc = pc; // ebreak address, pc parks here
    return exp_q.size();
  endfunction

  function automatic string sec_label(input logic [2:0] sec);
    case (sec)
      3'd1:    return "alu ops";
      3'd2:    return "lui/auipc";
      3'd3:    return "branches";
      3'd4:    return "jal/jalr";
      3'd5:    return "loads/stores";
      default: return "ebreak halt";
    endcase
  endfunction

  task automatic report_section(input logic [2:0] sec);
    $display("test %0d %s: %s (%0d errors)", sec, sec_label(sec),
             (sec_fail[sec] == 0) ? "ok" : "failed", sec_fail[sec]);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input logic [2:0] sec);
    check_cnt++;
    assert (got === exp) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
      fail_cnt++;
      sec_fail[sec]++;
    end
  endtask

  // store checker, mid-cycle when the outputs are settled
  always @(negedge clk) begin
    store_t e;
    if (!rst && dmem_we) begin
      check_cnt++;
      assert (exp_idx < exp_q.size()) else begin
        $display("%0t unexpected store to %h beyond the expected sequence", $time, dmem_addr);
        fail_cnt++;
        sec_fail[6]++;
      end
      if (exp_idx < exp_q.size()) begin
        e = exp_q[exp_idx];
        if (e.sec != cur_sec) begin
          report_section(cur_sec);
          cur_sec = e.sec;
        end
        check_value("dmem_addr", dmem_addr, e.addr, e.sec);
        check_value("dmem_wdata", dmem_wdata, e.data, e.sec);
        check_value("dmem_wmask", {28'h0, dmem_wmask}, {28'h0, e.mask}, e.sec);
        exp_idx++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout after %0d cycles without the core halting", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    void'($urandom(85));
    for (int i = 0; i < 7; i++) sec_fail[i] = 0;
    for (int i = 0; i < imem_words; i++) imem[i] = ebreak_insn;
    for (int i = 0; i < dmem_words; i++) dmem[i] = fill_word(dmem_base + 32'(i * 4));
    build_sec = 3'd1;
    put(utype(20'h00001, 5'd1, op_lui)); // x1 = data base
    alu_section();
    build_sec = 3'd2;
    upper_section();
    build_sec = 3'd3;
    branch_section();
    build_sec = 3'd4;
    jump_section();
    build_sec = 3'd5;
    memory_section();
    build_sec = 3'd6;
    halt_section();
    void'(run_model());
    cycle_limit = 2 * prog_len + 100;

    repeat (8) @(negedge clk);
    rst = 1'b0;
    while (!halt) @(negedge clk);
    repeat (hold_cycles) begin
      @(negedge clk);
      check_value("halt", {31'h0, halt}, 32'h1, 3'd6);
      check_value("imem_addr", imem_addr, hold_pc, 3'd6);
    end

    check_cnt++;
    assert (exp_idx == exp_q.size()) else begin
      $display("only %0d of %0d expected stores were seen", exp_idx, exp_q.size());
      fail_cnt++;
      sec_fail[cur_sec]++;
    end
    report_section(cur_sec);
    report_section(3'd6);
    $display("checks: %0d passed, %0d failed", check_cnt - fail_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+design
design/rv_pkg.sv
design/decode_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/writeback_stage.sv
design/riscv_core.sv
bench/tb_clock.sv
bench/core_assertions.sv
bench/tb_top.sv

//--- Makefile
# Verilator simulation of the RV32I core

VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
